//--- Makefile
# Verilator build and run for the cipher round controller testbench

VERILATOR ?= verilator
TOP       ?= cipher_ctrl_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# The log decides the result, the simulator status alone is not trusted
run: compile
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "^Result: PASSED$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- project.f
source/cipher_ctrl_pkg.sv
source/cipher_sparse_in.sv
source/cipher_ctrl_rail.sv
source/cipher_rail_vote.sv
source/cipher_rail_merge.sv
source/cipher_ctrl_top.sv
sim/cipher_ctrl_checker.sv
sim/cipher_ctrl_tb.sv

//--- sim/cipher_ctrl_checker.sv
// Redundancy and protocol assertions for the round controller
// Bound into the top level to watch the rails and the merged outputs
`timescale 1ns/1ns

module cipher_ctrl_checker (
  input logic                                                         clk_i,
  input logic                                                         rst_ni,
  input logic [cipher_ctrl_pkg::NumRails-1:0]                         rail_idle_i,
  input logic [cipher_ctrl_pkg::NumRails-1:0]                         rail_state_we_i,
  input cipher_ctrl_pkg::state_sel_e  [cipher_ctrl_pkg::NumRails-1:0] rail_state_sel_i,
  input cipher_ctrl_pkg::add_rk_sel_e [cipher_ctrl_pkg::NumRails-1:0] rail_add_rk_sel_i,
  input cipher_ctrl_pkg::round_ctr_t  [cipher_ctrl_pkg::NumRails-1:0] rail_round_i,
  input logic [cipher_ctrl_pkg::NumRails-1:0]                         rail_done_i,
  input logic [cipher_ctrl_pkg::NumRails-1:0]                         rail_alert_i,
  input logic                                                         idle_i,
  input logic                                                         state_we_i,
  input logic                                                         done_i,
  input logic                                                         alert_i
);

  logic rails_agree;

  // Every rail compared against rail 0
  always_comb begin : agree
    rails_agree = 1'b1;
    for (int i = 1; i < cipher_ctrl_pkg::NumRails; i++) begin
      if (rail_idle_i[i] != rail_idle_i[0] || rail_state_we_i[i] != rail_state_we_i[0] ||
          rail_state_sel_i[i] != rail_state_sel_i[0] ||
          rail_add_rk_sel_i[i] != rail_add_rk_sel_i[0] ||
          rail_round_i[i] != rail_round_i[0] ||
          rail_done_i[i] != rail_done_i[0] || rail_alert_i[i] != rail_alert_i[0]) begin
        rails_agree = 1'b0;
      end
    end
  end

  rails_agree_a: assert property (@(posedge clk_i) disable iff (!rst_ni) rails_agree)
    else $error("control rails disagree");

  done_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni) done_i |=> !done_i)
    else $error("done_o high for two cycles in a row");

  alert_sticky_a: assert property (@(posedge clk_i) disable iff (!rst_ni) alert_i |=> alert_i)
    else $error("alert_o dropped before reset");

  we_not_idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
                                  !(state_we_i && idle_i))
    else $error("state_we_o high while idle_o is high");

endmodule

bind cipher_ctrl_top cipher_ctrl_checker u_checker (
  .clk_i             ( clk_i           ),
  .rst_ni            ( rst_ni          ),
  .rail_idle_i       ( rail_idle       ),
  .rail_state_we_i   ( rail_state_we   ),
  .rail_state_sel_i  ( rail_state_sel  ),
  .rail_add_rk_sel_i ( rail_add_rk_sel ),
  .rail_round_i      ( rail_round      ),
  .rail_done_i       ( rail_done       ),
  .rail_alert_i      ( rail_alert      ),
  .idle_i            ( idle_o          ),
  .state_we_i        ( state_we_o      ),
  .done_i            ( done_o          ),
  .alert_i           ( alert_o         )
);

//--- sim/cipher_ctrl_tb.sv
// Directed testbench for the redundant cipher round controller
// Runs forward, inverse, busy-start and encoding error scenarios
`timescale 1ns/1ns

module cipher_ctrl_tb;

  localparam int ClkPeriod     = 8;
  localparam int NumRandRuns   = 6;
  localparam int RunCycles     = 20;  // Longest run (14 rounds) plus start and done cycles
  localparam int NumRuns       = 6 + NumRandRuns;
  localparam int TotalCycles   = NumRuns * RunCycles + 80; // Runs plus resets and error tests
  localparam int TimeoutFactor = 2;

  logic                                  clk_i;
  logic                                  rst_ni;
  logic [cipher_ctrl_pkg::Sp2VWidth-1:0] start_i;
  cipher_ctrl_pkg::key_len_e             key_len_i;
  cipher_ctrl_pkg::ciph_op_e             op_i;
  logic                                  idle_o;
  logic                                  state_we_o;
  cipher_ctrl_pkg::state_sel_e           state_sel_o;
  cipher_ctrl_pkg::add_rk_sel_e          add_rk_sel_o;
  cipher_ctrl_pkg::round_ctr_t           round_o;
  logic                                  done_o;
  logic                                  alert_o;
  integer                                seed;

  cipher_ctrl_top cipher_ctrl_top_i (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .start_i      ( start_i      ),
    .key_len_i    ( key_len_i    ),
    .op_i         ( op_i         ),
    .idle_o       ( idle_o       ),
    .state_we_o   ( state_we_o   ),
    .state_sel_o  ( state_sel_o  ),
    .add_rk_sel_o ( add_rk_sel_o ),
    .round_o      ( round_o      ),
    .done_o       ( done_o       ),
    .alert_o      ( alert_o      )
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin : watchdog
    #(TotalCycles * TimeoutFactor * ClkPeriod);
    $display("ERROR: watchdog expired before the tests finished");
    abort_run();
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string what);
    if (actual !== expected) begin
      $display("MISMATCH at %0t ns: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_outputs(input logic exp_idle, input logic exp_we,
                               input cipher_ctrl_pkg::state_sel_e exp_sel,
                               input cipher_ctrl_pkg::add_rk_sel_e exp_rk,
                               input int exp_round, input logic exp_done,
                               input logic exp_alert, input string tag);
    check_eq(32'(idle_o), 32'(exp_idle), $sformatf("%s: idle_o", tag));
    check_eq(32'(state_we_o), 32'(exp_we), $sformatf("%s: state_we_o", tag));
    check_eq(32'(state_sel_o), 32'(exp_sel), $sformatf("%s: state_sel_o", tag));
    check_eq(32'(add_rk_sel_o), 32'(exp_rk), $sformatf("%s: add_rk_sel_o", tag));
    check_eq(32'(round_o), 32'(exp_round), $sformatf("%s: round_o", tag));
    check_eq(32'(done_o), 32'(exp_done), $sformatf("%s: done_o", tag));
    check_eq(32'(alert_o), 32'(exp_alert), $sformatf("%s: alert_o", tag));
  endtask

  task automatic check_idle_outputs(input string tag);
    check_outputs(1'b1, 1'b0, cipher_ctrl_pkg::STATE_CLEAR, cipher_ctrl_pkg::ADD_RK_INIT,
                  0, 1'b0, 1'b0, tag);
  endtask

  task automatic check_error_outputs(input string tag);
    check_outputs(1'b0, 1'b0, cipher_ctrl_pkg::STATE_CLEAR, cipher_ctrl_pkg::ADD_RK_INIT,
                  0, 1'b0, 1'b1, tag);
  endtask

  function automatic int num_rounds(input cipher_ctrl_pkg::key_len_e kl);
    case (kl)
      cipher_ctrl_pkg::AES_192: return int'(cipher_ctrl_pkg::Rounds192);
      cipher_ctrl_pkg::AES_256: return int'(cipher_ctrl_pkg::Rounds256);
      default:                  return int'(cipher_ctrl_pkg::Rounds128);
    endcase
  endfunction

  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni  = 1'b0;
    start_i = cipher_ctrl_pkg::SP2V_LOW;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  task automatic wait_idle(input int max_cycles);
    int n;
    n = 0;
    while (!idle_o) begin
      if (n == max_cycles) begin
        $display("ERROR: idle_o did not return high within %0d cycles", max_cycles);
        abort_run();
      end else begin
        @(negedge clk_i);
        n++;
      end
    end
  endtask

  // One full run, checked cycle by cycle. A second start is sent in busy_round (0 = none)
  task automatic run_cipher(input cipher_ctrl_pkg::key_len_e kl,
                            input cipher_ctrl_pkg::ciph_op_e op, input int busy_round);
    int nr;
    int exp_round;
    cipher_ctrl_pkg::add_rk_sel_e exp_rk;
    nr        = num_rounds(kl);
    start_i   = cipher_ctrl_pkg::SP2V_HIGH;
    key_len_i = kl;
    op_i      = op;
    for (int e = 0; e < 2; e++) begin // Edges 0 and 1, rails still idle
      @(negedge clk_i);
      start_i = cipher_ctrl_pkg::SP2V_LOW;
      check_idle_outputs("start pending");
    end
    @(negedge clk_i);
    exp_round = (op == cipher_ctrl_pkg::CIPH_INV) ? nr : 0;
    check_outputs(1'b0, 1'b1, cipher_ctrl_pkg::STATE_INIT, cipher_ctrl_pkg::ADD_RK_INIT,
                  exp_round, 1'b0, 1'b0, "INIT");
    for (int r = 1; r <= nr; r++) begin
      @(negedge clk_i);
      exp_round = (op == cipher_ctrl_pkg::CIPH_INV) ? nr - r : r;
      exp_rk    = (r == nr) ? cipher_ctrl_pkg::ADD_RK_FINAL : cipher_ctrl_pkg::ADD_RK_ROUND;
      check_outputs(1'b0, 1'b1, cipher_ctrl_pkg::STATE_ROUND, exp_rk, exp_round, 1'b0, 1'b0,
                    $sformatf("round %0d", r));
      if (r == busy_round) begin // Other config, must be ignored
        start_i   = cipher_ctrl_pkg::SP2V_HIGH;
        key_len_i = cipher_ctrl_pkg::AES_256;
        op_i      = (op == cipher_ctrl_pkg::CIPH_FWD) ? cipher_ctrl_pkg::CIPH_INV :
                                                        cipher_ctrl_pkg::CIPH_FWD;
      end else begin
        start_i = cipher_ctrl_pkg::SP2V_LOW;
      end
    end
    @(negedge clk_i); // Nr+3 edges after start
    check_outputs(1'b0, 1'b0, cipher_ctrl_pkg::STATE_CLEAR, cipher_ctrl_pkg::ADD_RK_INIT,
                  0, 1'b1, 1'b0, "done");
    @(negedge clk_i);
    check_idle_outputs("after done");
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic check_reset_state();
    repeat (4) begin
      @(negedge clk_i);
      check_idle_outputs("reset state");
    end
  endtask

  task automatic run_forward_all();
    run_cipher(cipher_ctrl_pkg::AES_128, cipher_ctrl_pkg::CIPH_FWD, 0);
    run_cipher(cipher_ctrl_pkg::AES_192, cipher_ctrl_pkg::CIPH_FWD, 0);
    run_cipher(cipher_ctrl_pkg::AES_256, cipher_ctrl_pkg::CIPH_FWD, 0);
  endtask

  task automatic run_inverse_and_random();
    logic [31:0] rnd;
    cipher_ctrl_pkg::key_len_e kl;
    cipher_ctrl_pkg::ciph_op_e op;
    run_cipher(cipher_ctrl_pkg::AES_256, cipher_ctrl_pkg::CIPH_INV, 0);
    repeat (NumRandRuns) begin
      rnd = $random(seed);
      case (rnd[31:0] % 3)
        0:       kl = cipher_ctrl_pkg::AES_128;
        1:       kl = cipher_ctrl_pkg::AES_192;
        default: kl = cipher_ctrl_pkg::AES_256;
      endcase
      op = rnd[4] ? cipher_ctrl_pkg::CIPH_INV : cipher_ctrl_pkg::CIPH_FWD;
      wait_idle(4);
      run_cipher(kl, op, 0);
    end
  endtask

  task automatic ignore_busy_start();
    run_cipher(cipher_ctrl_pkg::AES_128, cipher_ctrl_pkg::CIPH_FWD, 3);
    repeat (3) begin // No second run, no second done
      @(negedge clk_i);
      check_idle_outputs("after busy start");
    end
  endtask

  task automatic reject_bad_start();
    logic [cipher_ctrl_pkg::Sp2VWidth-1:0] bad;
    do begin
      bad = 3'($random(seed));
    end while (bad == cipher_ctrl_pkg::SP2V_HIGH || bad == cipher_ctrl_pkg::SP2V_LOW);
    start_i = bad;
    for (int e = 0; e < 2; e++) begin // Flagged after edge 1
      @(negedge clk_i);
      start_i = cipher_ctrl_pkg::SP2V_LOW;
      check_idle_outputs("bad start pending");
    end
    @(negedge clk_i);
    check_error_outputs("bad start error");
    repeat (2) begin // Locked until reset
      start_i   = cipher_ctrl_pkg::SP2V_HIGH;
      key_len_i = cipher_ctrl_pkg::AES_128;
      op_i      = cipher_ctrl_pkg::CIPH_FWD;
      @(negedge clk_i);
      start_i = cipher_ctrl_pkg::SP2V_LOW;
      repeat (6) begin
        check_error_outputs("start after error");
        @(negedge clk_i);
      end
    end
  endtask

  task automatic reject_bad_key_len();
    logic [2:0] bad_kl;
    apply_reset();
    do begin
      bad_kl = 3'($random(seed));
    end while ($countones(bad_kl) == 1);
    start_i   = cipher_ctrl_pkg::SP2V_HIGH;
    key_len_i = cipher_ctrl_pkg::key_len_e'(bad_kl);
    for (int e = 0; e < 2; e++) begin
      @(negedge clk_i);
      start_i = cipher_ctrl_pkg::SP2V_LOW;
      check_idle_outputs("bad key length pending");
    end
    @(negedge clk_i);
    check_error_outputs("bad key length error");
    apply_reset();
    run_cipher(cipher_ctrl_pkg::AES_128, cipher_ctrl_pkg::CIPH_FWD, 0);
  endtask

  initial begin
    seed      = 32'h0386_f03b;
    rst_ni    = 1'b0;
    start_i   = cipher_ctrl_pkg::SP2V_LOW;
    key_len_i = cipher_ctrl_pkg::AES_128;
    op_i      = cipher_ctrl_pkg::CIPH_FWD;
    apply_reset();
    check_reset_state();
    run_forward_all();
    run_inverse_and_random();
    ignore_busy_start();
    reject_bad_start();
    reject_bad_key_len();
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- source/cipher_ctrl_pkg.sv
// Shared widths, sparse codes and select encodings for the
// redundant cipher round controller
package cipher_ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // Sparse two-value words
  ////////////////////////////////////////////////////////////

  localparam int Sp2VWidth = 3;

  // Only these two codes are legal, everything else is an error
  localparam logic [Sp2VWidth-1:0] SP2V_HIGH = 3'b011;
  localparam logic [Sp2VWidth-1:0] SP2V_LOW  = 3'b100;

  ////////////////////////////////////////////////////////////
  // Rails and rounds
  ////////////////////////////////////////////////////////////

  localparam int NumRails      = 3;
  localparam int RoundCtrWidth = 4; // Holds up to 14 rounds

  typedef logic [RoundCtrWidth-1:0] round_ctr_t;

  localparam round_ctr_t Rounds128 = round_ctr_t'(10);
  localparam round_ctr_t Rounds192 = round_ctr_t'(12);
  localparam round_ctr_t Rounds256 = round_ctr_t'(14);

  ////////////////////////////////////////////////////////////
  // Configuration and select encodings
  ////////////////////////////////////////////////////////////

  // One-hot key length
  typedef enum logic [2:0] {
    AES_128 = 3'b001,
    AES_192 = 3'b010,
    AES_256 = 3'b100
  } key_len_e;

  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  // State register input select, one-hot
  typedef enum logic [2:0] {
    STATE_INIT  = 3'b001,
    STATE_ROUND = 3'b010,
    STATE_CLEAR = 3'b100
  } state_sel_e;

  // Round key select, one-hot
  typedef enum logic [2:0] {
    ADD_RK_INIT  = 3'b001,
    ADD_RK_ROUND = 3'b010,
    ADD_RK_FINAL = 3'b100
  } add_rk_sel_e;

endpackage

//--- source/cipher_ctrl_rail.sv
// Single control rail of the round controller
// Walks through key addition, the rounds and a done cycle, and locks up
// in a terminal error state on any encoding or rail mismatch error
`timescale 1ns/1ns

module cipher_ctrl_rail (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           start_i,
  input  cipher_ctrl_pkg::key_len_e      key_len_i,
  input  cipher_ctrl_pkg::ciph_op_e      op_i,
  input  logic                           enc_err_i,
  input  logic                           mr_err_i,
  output logic                           idle_o,
  output logic                           state_we_o,
  output cipher_ctrl_pkg::state_sel_e    state_sel_o,
  output cipher_ctrl_pkg::add_rk_sel_e   add_rk_sel_o,
  output cipher_ctrl_pkg::round_ctr_t    round_o,
  output logic                           done_o,
  output logic                           alert_o
);

  typedef enum logic [2:0] {
    IDLE   = 3'b000,
    INIT   = 3'b011,
    ROUND  = 3'b101,
    FINISH = 3'b110,
    ERROR  = 3'b111
  } rail_state_e;

  rail_state_e                 state_d, state_q;
  cipher_ctrl_pkg::round_ctr_t rnd_ctr_d, rnd_ctr_q;   // Round number driven out
  cipher_ctrl_pkg::round_ctr_t rnd_left_d, rnd_left_q; // Rounds still to go
  cipher_ctrl_pkg::round_ctr_t rnd_ctr_step;
  cipher_ctrl_pkg::round_ctr_t num_rounds;
  cipher_ctrl_pkg::ciph_op_e   op_d, op_q;
  logic                        last_round;

  // Round count per key length
  always_comb begin
    case (key_len_i)
      cipher_ctrl_pkg::AES_192: num_rounds = cipher_ctrl_pkg::Rounds192;
      cipher_ctrl_pkg::AES_256: num_rounds = cipher_ctrl_pkg::Rounds256;
      default:                  num_rounds = cipher_ctrl_pkg::Rounds128;
    endcase
  end

  // Inverse runs count down
  assign rnd_ctr_step = (op_q == cipher_ctrl_pkg::CIPH_INV) ?
                        rnd_ctr_q - cipher_ctrl_pkg::round_ctr_t'(1) :
                        rnd_ctr_q + cipher_ctrl_pkg::round_ctr_t'(1);
  assign last_round   = (rnd_left_q == cipher_ctrl_pkg::round_ctr_t'(1));

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb begin : fsm_comb
    state_d      = state_q;
    rnd_ctr_d    = rnd_ctr_q;
    rnd_left_d   = rnd_left_q;
    op_d         = op_q;
    idle_o       = 1'b0;
    state_we_o   = 1'b0;
    state_sel_o  = cipher_ctrl_pkg::STATE_CLEAR;
    add_rk_sel_o = cipher_ctrl_pkg::ADD_RK_INIT;
    round_o      = '0;
    done_o       = 1'b0;
    alert_o      = 1'b0;

    case (state_q)
      IDLE: begin
        idle_o = 1'b1;
        if (start_i) begin
          // Latch the configuration with the accepted start
          op_d       = op_i;
          rnd_left_d = num_rounds;
          rnd_ctr_d  = (op_i == cipher_ctrl_pkg::CIPH_INV) ? num_rounds : '0;
          state_d    = INIT;
        end
      end

      INIT: begin // Initial key addition
        state_we_o   = 1'b1;
        state_sel_o  = cipher_ctrl_pkg::STATE_INIT;
        add_rk_sel_o = cipher_ctrl_pkg::ADD_RK_INIT;
        round_o      = rnd_ctr_q;
        rnd_ctr_d    = rnd_ctr_step;
        state_d      = ROUND;
      end

      ROUND: begin
        state_we_o   = 1'b1;
        state_sel_o  = cipher_ctrl_pkg::STATE_ROUND;
        add_rk_sel_o = last_round ? cipher_ctrl_pkg::ADD_RK_FINAL :
                                    cipher_ctrl_pkg::ADD_RK_ROUND;
        round_o      = rnd_ctr_q;
        if (last_round) begin
          state_d = FINISH;
        end else begin
          rnd_left_d = rnd_left_q - cipher_ctrl_pkg::round_ctr_t'(1);
          rnd_ctr_d  = rnd_ctr_step;
        end
      end

      FINISH: begin
        done_o  = 1'b1; // One-cycle strobe
        state_d = IDLE;
      end

      ERROR: begin
        alert_o = 1'b1; // Terminal, only reset leaves
      end

      default: begin
        state_d = ERROR;
      end
    endcase

    // Errors override any other transition
    if (enc_err_i || mr_err_i) begin
      state_d = ERROR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : fsm_regs
    if (!rst_ni) begin
      state_q    <= IDLE;
      rnd_ctr_q  <= '0;
      rnd_left_q <= '0;
      op_q       <= cipher_ctrl_pkg::CIPH_FWD;
    end else begin
      state_q    <= state_d;
      rnd_ctr_q  <= rnd_ctr_d;
      rnd_left_q <= rnd_left_d;
      op_q       <= op_d;
    end
  end

endmodule

//--- source/cipher_ctrl_top.sv
// Redundant round controller for an AES-style cipher core
// Input check stage, a set of identical control rails and the merge stage
`timescale 1ns/1ns

module cipher_ctrl_top (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic [cipher_ctrl_pkg::Sp2VWidth-1:0] start_i,
  input  cipher_ctrl_pkg::key_len_e             key_len_i,
  input  cipher_ctrl_pkg::ciph_op_e             op_i,
  output logic                                  idle_o,
  output logic                                  state_we_o,
  output cipher_ctrl_pkg::state_sel_e           state_sel_o,
  output cipher_ctrl_pkg::add_rk_sel_e          add_rk_sel_o,
  output cipher_ctrl_pkg::round_ctr_t           round_o,
  output logic                                  done_o,
  output logic                                  alert_o
);

  logic                      start;
  cipher_ctrl_pkg::key_len_e key_len;
  logic                      enc_err;
  logic                      mr_err;

  // Per-rail outputs
  logic [cipher_ctrl_pkg::NumRails-1:0]                        rail_idle;
  logic [cipher_ctrl_pkg::NumRails-1:0]                        rail_state_we;
  cipher_ctrl_pkg::state_sel_e  [cipher_ctrl_pkg::NumRails-1:0] rail_state_sel;
  cipher_ctrl_pkg::add_rk_sel_e [cipher_ctrl_pkg::NumRails-1:0] rail_add_rk_sel;
  cipher_ctrl_pkg::round_ctr_t  [cipher_ctrl_pkg::NumRails-1:0] rail_round;
  logic [cipher_ctrl_pkg::NumRails-1:0]                        rail_done;
  logic [cipher_ctrl_pkg::NumRails-1:0]                        rail_alert;

  cipher_sparse_in u_sparse_in (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .start_i   ( start_i   ),
    .key_len_i ( key_len_i ),
    .start_o   ( start     ),
    .key_len_o ( key_len   ),
    .enc_err_o ( enc_err   )
  );

  ////////////////////////////////////////////////////////////
  // Redundant rails
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < cipher_ctrl_pkg::NumRails; i++) begin : gen_rail
    cipher_ctrl_rail u_rail (
      .clk_i        ( clk_i              ),
      .rst_ni       ( rst_ni             ),
      .start_i      ( start              ),
      .key_len_i    ( key_len            ),
      .op_i         ( op_i               ),
      .enc_err_i    ( enc_err            ),
      .mr_err_i     ( mr_err             ),
      .idle_o       ( rail_idle[i]       ),
      .state_we_o   ( rail_state_we[i]   ),
      .state_sel_o  ( rail_state_sel[i]  ),
      .add_rk_sel_o ( rail_add_rk_sel[i] ),
      .round_o      ( rail_round[i]      ),
      .done_o       ( rail_done[i]       ),
      .alert_o      ( rail_alert[i]      )
    );
  end

  cipher_rail_merge u_rail_merge (
    .rail_idle_i       ( rail_idle       ),
    .rail_state_we_i   ( rail_state_we   ),
    .rail_state_sel_i  ( rail_state_sel  ),
    .rail_add_rk_sel_i ( rail_add_rk_sel ),
    .rail_round_i      ( rail_round      ),
    .rail_done_i       ( rail_done       ),
    .rail_alert_i      ( rail_alert      ),
    .idle_o            ( idle_o          ),
    .state_we_o        ( state_we_o      ),
    .state_sel_o       ( state_sel_o     ),
    .add_rk_sel_o      ( add_rk_sel_o    ),
    .round_o           ( round_o         ),
    .done_o            ( done_o          ),
    .alert_o           ( alert_o         ),
    .mr_err_o          ( mr_err          )
  );

endmodule

//--- source/cipher_rail_merge.sv
// Output stage of the round controller
// Votes every rail output into the top outputs and collects the mismatch error
`timescale 1ns/1ns

module cipher_rail_merge (
  input  logic [cipher_ctrl_pkg::NumRails-1:0]                        rail_idle_i,
  input  logic [cipher_ctrl_pkg::NumRails-1:0]                        rail_state_we_i,
  input  cipher_ctrl_pkg::state_sel_e  [cipher_ctrl_pkg::NumRails-1:0] rail_state_sel_i,
  input  cipher_ctrl_pkg::add_rk_sel_e [cipher_ctrl_pkg::NumRails-1:0] rail_add_rk_sel_i,
  input  cipher_ctrl_pkg::round_ctr_t  [cipher_ctrl_pkg::NumRails-1:0] rail_round_i,
  input  logic [cipher_ctrl_pkg::NumRails-1:0]                        rail_done_i,
  input  logic [cipher_ctrl_pkg::NumRails-1:0]                        rail_alert_i,
  output logic                                                        idle_o,
  output logic                                                        state_we_o,
  output cipher_ctrl_pkg::state_sel_e                                 state_sel_o,
  output cipher_ctrl_pkg::add_rk_sel_e                                add_rk_sel_o,
  output cipher_ctrl_pkg::round_ctr_t                                 round_o,
  output logic                                                        done_o,
  output logic                                                        alert_o,
  output logic                                                        mr_err_o
);

  logic state_sel_err;
  logic add_rk_sel_err;
  logic round_err;
  logic state_we_err;
  logic idle_err;

  ////////////////////////////////////////////////////////////
  // Checked outputs
  ////////////////////////////////////////////////////////////

  cipher_rail_vote #(
    .payload_t ( cipher_ctrl_pkg::state_sel_e )
  ) u_vote_state_sel (
    .rail_i   ( rail_state_sel_i ),
    .merged_o ( state_sel_o      ),
    .err_o    ( state_sel_err    )
  );

  cipher_rail_vote #(
    .payload_t ( cipher_ctrl_pkg::add_rk_sel_e )
  ) u_vote_add_rk_sel (
    .rail_i   ( rail_add_rk_sel_i ),
    .merged_o ( add_rk_sel_o      ),
    .err_o    ( add_rk_sel_err    )
  );

  cipher_rail_vote #(
    .payload_t ( cipher_ctrl_pkg::round_ctr_t )
  ) u_vote_round (
    .rail_i   ( rail_round_i ),
    .merged_o ( round_o      ),
    .err_o    ( round_err    )
  );

  cipher_rail_vote u_vote_state_we (
    .rail_i   ( rail_state_we_i ),
    .merged_o ( state_we_o      ),
    .err_o    ( state_we_err    )
  );

  cipher_rail_vote u_vote_idle (
    .rail_i   ( rail_idle_i ),
    .merged_o ( idle_o      ),
    .err_o    ( idle_err    )
  );

  // Fed back to the rails, pushes all of them into ERROR
  assign mr_err_o = state_sel_err | add_rk_sel_err | round_err | state_we_err | idle_err;

  // One rail suffices to raise these
  assign done_o  = |rail_done_i;
  assign alert_o = |rail_alert_i;

endmodule

//--- source/cipher_rail_vote.sv
// Merges one payload across all rails by OR
// and flags any rail that differs from the merged value
`timescale 1ns/1ns

module cipher_rail_vote #(
  parameter type payload_t = logic
) (
  input  payload_t [cipher_ctrl_pkg::NumRails-1:0] rail_i,
  output payload_t                                 merged_o,
  output logic                                     err_o
);

  payload_t merged;

  // OR-combine, a single high bit in any rail shows up at the output
  always_comb begin : combine
    merged = payload_t'('0);
    for (int i = 0; i < cipher_ctrl_pkg::NumRails; i++) begin
      merged = payload_t'(merged | rail_i[i]);
    end
  end

  // A rail that disagrees with the merged value is a fault
  always_comb begin : compare
    err_o = 1'b0;
    for (int i = 0; i < cipher_ctrl_pkg::NumRails; i++) begin
      if (rail_i[i] != merged) begin
        err_o = 1'b1;
      end
    end
  end

  assign merged_o = merged;

endmodule

//--- source/cipher_sparse_in.sv
// Input stage of the round controller
// Captures the sparse start and key-length words, checks their encodings
// and hands the decoded values to the rails one cycle later
`timescale 1ns/1ns

module cipher_sparse_in (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic [cipher_ctrl_pkg::Sp2VWidth-1:0] start_i,
  input  cipher_ctrl_pkg::key_len_e             key_len_i,
  output logic                                  start_o,
  output cipher_ctrl_pkg::key_len_e             key_len_o,
  output logic                                  enc_err_o
);

  logic [cipher_ctrl_pkg::Sp2VWidth-1:0] start_raw_q;
  cipher_ctrl_pkg::key_len_e             key_len_raw_q;
  cipher_ctrl_pkg::key_len_e             key_len_q;
  logic                                  start_vld;
  logic                                  start_err;
  logic                                  key_len_err;
  logic                                  start_q;
  logic                                  enc_err_q;

  // Raw capture of the external words
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_raw_q <= cipher_ctrl_pkg::SP2V_LOW;
    end else begin
      start_raw_q <= start_i;
    end
  end

  always_ff @(posedge clk_i) begin
    key_len_raw_q <= key_len_i;
  end

  // Encoding checks
  assign start_vld = (start_raw_q == cipher_ctrl_pkg::SP2V_HIGH);
  assign start_err = (start_raw_q != cipher_ctrl_pkg::SP2V_HIGH) &&
                     (start_raw_q != cipher_ctrl_pkg::SP2V_LOW);

  // Key length only matters together with a start
  assign key_len_err = start_vld && !(key_len_raw_q inside {cipher_ctrl_pkg::AES_128,
                                                            cipher_ctrl_pkg::AES_192,
                                                            cipher_ctrl_pkg::AES_256});

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q   <= 1'b0;
      enc_err_q <= 1'b0;
    end else begin
      start_q   <= start_vld;
      enc_err_q <= enc_err_q | start_err | key_len_err; // Sticky
    end
  end

  always_ff @(posedge clk_i) begin
    key_len_q <= key_len_raw_q;
  end

  assign start_o   = start_q;
  assign key_len_o = key_len_q;
  assign enc_err_o = enc_err_q;

endmodule
